//--- common/gb_cart_pkg.sv
package gb_cart_pkg;

	// ------------------------------------------------------------------------
	// widths
	// ------------------------------------------------------------------------
	localparam int mem_addr_w_default = 24;	// external memory, 16-bit words
	localparam int rom_bank_w         = 7;	// up to 128 banks of 16k
	localparam int ram_bank_w         = 2;	// up to 4 banks of 8k
	localparam int mbc_kind_w         = 3;

	// controller kind codes, decoded from header byte 0x147
	localparam logic [mbc_kind_w-1:0] kind_none = 3'd0;	// also mmm01, mbc4, tama5, huc
	localparam logic [mbc_kind_w-1:0] kind_mbc1 = 3'd1;
	localparam logic [mbc_kind_w-1:0] kind_mbc2 = 3'd2;
	localparam logic [mbc_kind_w-1:0] kind_mbc3 = 3'd3;	// rtc select only, no clock
	localparam logic [mbc_kind_w-1:0] kind_mbc5 = 3'd4;

	// header byte addresses as seen on the download port
	// type sits in the high byte of the word at 0x146
	// ram size in the high byte and rom size in the low byte at 0x148
	localparam logic [24:0] hdr_type_addr = 25'h146;
	localparam logic [24:0] hdr_size_addr = 25'h148;

	// ------------------------------------------------------------------------
	// console address regions, cart_addr[15:13]
	// ------------------------------------------------------------------------
	localparam logic [2:0] region_ram_en   = 3'b000;	// 0000-1fff write
	localparam logic [2:0] region_rom_bank = 3'b001;	// 2000-3fff write
	localparam logic [2:0] region_ram_bank = 3'b010;	// 4000-5fff write
	localparam logic [2:0] region_mode     = 3'b011;	// 6000-7fff write
	localparam logic [2:0] region_ext_ram  = 3'b101;	// a000-bfff read/write

	// one console write byte, seen either as a rom bank number or as a
	// ram bank select with the mbc3 rtc flag in bit 3
	typedef struct packed {
		logic                  rsvd;
		logic [rom_bank_w-1:0] bank;
	} rom_view_t;

	typedef struct packed {
		logic [3:0]            rsvd;
		logic                  rtc_sel;	// mbc3 only, 08..0c picks an rtc reg
		logic                  spare;
		logic [ram_bank_w-1:0] bank;
	} ram_view_t;

	typedef union packed {
		rom_view_t rom;
		ram_view_t ram;
	} cart_wdata_u;

endpackage

//--- common/cart_info_if.sv
`timescale 1ns/1ps

// cartridge facts taken from the header while the rom is downloaded
interface cart_info_if;
	import gb_cart_pkg::*;

	logic                  ready;		// first word committed to memory
	logic [mbc_kind_w-1:0] kind;		// controller type
	logic [rom_bank_w-1:0] rom_mask;	// rom bank mirroring
	logic [ram_bank_w-1:0] ram_mask;	// ram bank mirroring

	modport src (
		output ready,
		output kind,
		output rom_mask,
		output ram_mask
	);

	modport snk (
		input ready,
		input kind,
		input rom_mask,
		input ram_mask
	);

endinterface

//--- common/mbc_state_if.sv
`timescale 1ns/1ps

// banking state as written by the console
interface mbc_state_if;
	import gb_cart_pkg::*;

	logic [rom_bank_w-1:0] rom_bank;	// raw register, masked later
	logic [ram_bank_w-1:0] ram_bank;	// also upper rom bits on mbc1 mode 0
	logic                  mbc1_mode;	// 0 = 16/8, 1 = 4/32
	logic                  mbc3_rtc;	// a000-bfff points at the rtc
	logic                  ram_enable;

	modport regs (
		output rom_bank,
		output ram_bank,
		output mbc1_mode,
		output mbc3_rtc,
		output ram_enable
	);

	modport map (
		input rom_bank,
		input ram_bank,
		input mbc1_mode,
		input mbc3_rtc,
		input ram_enable
	);

endinterface

//--- loader/rom_loader.sv
`timescale 1ns/1ps

module rom_loader #(
	parameter int ce_div_log2 = 3			// ce_cpu every 2**n clocks
) (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        dl_active,
	input  logic        dl_wr,
	input  logic [24:0] dl_addr,
	input  logic [15:0] dl_data,
	output logic        dl_wait,
	output logic        dl_write,			// memory write request for the held word
	output logic        ce_cpu,
	cart_info_if.src    info
);
	import gb_cart_pkg::*;

	logic [ce_div_log2-1:0] div;
	logic [7:0]             type_byte;		// header 0x147
	logic [7:0]             rom_size;		// header 0x148
	logic [7:0]             ram_size;		// header 0x149

	// ------------------------------------------------------------------------
	// console clock enable, one pulse per turn of the divider
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			div    <= '0;
			ce_cpu <= 1'b0;
		end else begin
			div    <= div + 1'b1;
			ce_cpu <= (div == '0);		// first pulse one clock out of reset
		end
	end

	// download handshake
	// wait goes up on the host write, the flag follows on the next enable
	// and both drop on the enable after, which is when memory takes the word
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_wait    <= 1'b0;
			dl_write   <= 1'b0;
			info.ready <= 1'b0;
		end else begin
			if (dl_wr)
				dl_wait <= 1'b1;
			if (ce_cpu) begin
				dl_write <= dl_wait;
				if (dl_write) begin
					dl_wait    <= 1'b0;
					dl_write   <= 1'b0;
					info.ready <= 1'b1;	// sticky once anything landed
				end
			end
		end
	end

	// header capture straight off the port, no need to read back memory
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			type_byte <= 8'h00;
			rom_size  <= 8'h00;
			ram_size  <= 8'h00;
		end else if (dl_active && dl_wr) begin
			if (dl_addr == hdr_type_addr)
				type_byte <= dl_data[15:8];
			if (dl_addr == hdr_size_addr)
				{ram_size, rom_size} <= dl_data;
		end
	end

	// ------------------------------------------------------------------------
	// header decode
	// ------------------------------------------------------------------------
	always_comb begin
		case (type_byte)
			8'h01, 8'h02, 8'h03:                      info.kind = kind_mbc1;
			8'h05, 8'h06:                             info.kind = kind_mbc2;
			8'h0f, 8'h10, 8'h11, 8'h12, 8'h13:        info.kind = kind_mbc3;
			8'h19, 8'h1a, 8'h1b, 8'h1c, 8'h1d, 8'h1e: info.kind = kind_mbc5;
			default:                                  info.kind = kind_none;
		endcase

		case (rom_size)
			8'h00:   info.rom_mask = 7'h01;	// 32k, two banks
			8'h01:   info.rom_mask = 7'h03;
			8'h02:   info.rom_mask = 7'h07;
			8'h03:   info.rom_mask = 7'h0f;
			8'h04:   info.rom_mask = 7'h1f;
			8'h05:   info.rom_mask = 7'h3f;
			8'h06:   info.rom_mask = 7'h7f;	// 2M
			8'h52:   info.rom_mask = 7'h47;	// 72 banks
			8'h53:   info.rom_mask = 7'h4f;	// 80 banks
			default: info.rom_mask = 7'h5f;	// 54 = 96 banks, odd codes land here too
		endcase

		// 2k and 8k parts have one bank, anything larger gets four
		info.ram_mask = (ram_size <= 8'h02) ? 2'b00 : 2'b11;
	end

	// the host may only strobe while the loader is idle
	a_no_wr_while_wait: assert property (
		@(posedge clk_sys) disable iff (reset)
		dl_wr |-> !dl_wait
	);

endmodule

//--- mbc/mbc_regs.sv
`timescale 1ns/1ps

module mbc_regs (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        dl_active,
	input  logic        ce_cpu,
	input  logic [15:0] cart_addr,
	input  logic        cart_wr,
	input  logic [7:0]  cart_di,
	cart_info_if.snk    info,
	mbc_state_if.regs   state
);
	import gb_cart_pkg::*;

	cart_wdata_u wdata;
	logic [2:0]  region;
	logic        wr_en;

	assign wdata  = cart_di;
	assign region = cart_addr[15:13];
	assign wr_en  = ce_cpu && cart_wr;	// console bus is only valid on enables

	// ------------------------------------------------------------------------
	// bank and mode registers
	// a new download puts everything back to power-up state
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset || dl_active) begin
			state.rom_bank   <= 7'd1;
			state.ram_bank   <= 2'd0;
			state.mbc1_mode  <= 1'b0;
			state.mbc3_rtc   <= 1'b0;
			state.ram_enable <= 1'b0;
		end else if (wr_en) begin
			case (region)
				region_ram_en: begin
					state.ram_enable <= (cart_di[3:0] == 4'ha);	// only 0a unlocks
				end
				region_rom_bank: begin
					// bank 0 can't be paged in at 4000 except on mbc5
					if (info.kind != kind_mbc5 && wdata.rom.bank[4:0] == 5'd0)
						state.rom_bank <= 7'd1;
					else
						state.rom_bank <= wdata.rom.bank;
				end
				region_ram_bank: begin
					if (info.kind == kind_mbc3) begin
						if (wdata.ram.rtc_sel) begin
							state.mbc3_rtc <= 1'b1;		// rtc register visible at a000
						end else begin
							state.mbc3_rtc <= 1'b0;
							state.ram_bank <= wdata.ram.bank;
						end
					end else begin
						state.ram_bank <= wdata.ram.bank;	// mbc1 upper rom bits too
					end
				end
				region_mode: begin
					if (info.kind == kind_mbc1)
						state.mbc1_mode <= cart_di[0];
				end
				default: ;	// rom reads and ext ram writes are not registers
			endcase
		end
	end

	// holds across the loader's kind decode and the write logic here
	a_rom_bank_nonzero: assert property (
		@(posedge clk_sys) disable iff (reset)
		(info.kind != kind_mbc5) |-> (state.rom_bank != '0)
	);

endmodule

//--- mbc/cart_mem_port.sv
`timescale 1ns/1ps

module cart_mem_port #(
	parameter int mem_addr_w = gb_cart_pkg::mem_addr_w_default
) (
	input  logic                  dl_active,
	input  logic                  dl_write,
	input  logic [24:0]           dl_addr,
	input  logic [15:0]           dl_data,
	input  logic [15:0]           cart_addr,
	input  logic                  cart_rd,
	input  logic                  cart_wr,
	input  logic [7:0]            cart_di,
	cart_info_if.snk              info,
	mbc_state_if.map              state,
	output logic [mem_addr_w-1:0] mem_addr,
	output logic [15:0]           mem_din,
	output logic [1:0]            mem_ds,
	output logic                  mem_we,
	output logic                  mem_oe,
	input  logic [15:0]           mem_dout,
	output logic [7:0]            cart_do
);
	import gb_cart_pkg::*;

	// word map: bank in bits 20..12, byte offset/2 below
	// bank 000-0ff is rom, 100-103 is cart ram, mbc2 ram shares 100

	logic                  is_rom0;		// 0000-3fff
	logic                  is_romx;		// 4000-7fff
	logic                  is_ext_ram;	// a000-bfff
	logic                  is_mbc2_ram;	// a000-a1ff, 512 nibbles inside mbc2
	logic [rom_bank_w-1:0] rom_bank_m;
	logic [ram_bank_w-1:0] ram_bank_m;
	logic [8:0]            ram_sel;
	logic [8:0]            bank;
	logic                  cart_ram_wr;
	logic [7:0]            rd_byte;

	assign is_rom0     = (cart_addr[15:14] == 2'b00);
	assign is_romx     = (cart_addr[15:14] == 2'b01);
	assign is_ext_ram  = (cart_addr[15:13] == region_ext_ram);
	assign is_mbc2_ram = (cart_addr[15:9] == 7'b1010000);

	// ------------------------------------------------------------------------
	// bank forming
	// ------------------------------------------------------------------------
	always_comb begin
		// mbc1 mode 0 borrows the ram bank as rom bits 6:5 and leaves ram unbanked
		if (info.kind == kind_mbc1) begin
			rom_bank_m = {state.mbc1_mode ? 2'b00 : state.ram_bank,
				state.rom_bank[4:0]} & info.rom_mask;
			ram_bank_m = (state.mbc1_mode ? state.ram_bank : 2'b00) & info.ram_mask;
		end else begin
			rom_bank_m = state.rom_bank & info.rom_mask;	// mirroring
			ram_bank_m = state.ram_bank & info.ram_mask;
		end
	end

	assign ram_sel = {7'b1000000, ram_bank_m};

	always_comb begin
		bank = 9'd0;
		if (info.kind == kind_none)
			bank = {7'd0, cart_addr[14:13]};		// plain 32k, linear
		else if (is_rom0)
			bank = {8'd0, cart_addr[13]};
		else if (is_romx)
			bank = {1'b0, rom_bank_m, cart_addr[13]};
		else if (is_ext_ram) begin
			case (info.kind)
				kind_mbc2: bank = is_mbc2_ram ? 9'h100 : 9'd0;
				kind_mbc3: bank = state.mbc3_rtc ? 9'd0 : ram_sel;	// rtc reads bank 0
				default:   bank = ram_sel;
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// memory request, download owns the port while active
	// ------------------------------------------------------------------------
	assign cart_ram_wr = cart_wr && state.ram_enable && is_ext_ram;

	assign mem_addr = dl_active ? mem_addr_w'(dl_addr[24:1]) :
		mem_addr_w'({bank, cart_addr[12:1]});
	assign mem_ds   = dl_active ? 2'b11 : {cart_addr[0], ~cart_addr[0]};	// byte lane
	assign mem_din  = dl_active ? dl_data : {cart_di, cart_di};
	assign mem_we   = dl_active ? dl_write : cart_ram_wr;
	assign mem_oe   = ~dl_active & cart_rd;

	// read shaping
	assign rd_byte = cart_addr[0] ? mem_dout[15:8] : mem_dout[7:0];

	always_comb begin
		if (!info.ready)
			cart_do = 8'h00;					// nothing loaded yet
		else if (is_ext_ram && !state.ram_enable)
			cart_do = 8'hff;					// locked ram floats high
		else if (is_mbc2_ram && info.kind == kind_mbc2)
			cart_do = {4'hf, rd_byte[3:0]};	// only 4 bits per cell
		else
			cart_do = rd_byte;
	end

endmodule

//--- logic/gb_cart_top.sv
`timescale 1ns/1ps

module gb_cart_top #(
	parameter int mem_addr_w = gb_cart_pkg::mem_addr_w_default
) (
	input  logic                  clk_sys,
	input  logic                  reset,

	// host download
	input  logic                  dl_active,
	input  logic                  dl_wr,
	input  logic [24:0]           dl_addr,
	input  logic [15:0]           dl_data,
	output logic                  dl_wait,

	// console cartridge bus
	input  logic [15:0]           cart_addr,
	input  logic                  cart_rd,
	input  logic                  cart_wr,
	input  logic [7:0]            cart_di,
	output logic [7:0]            cart_do,
	output logic                  ce_cpu,

	// external word memory
	output logic [mem_addr_w-1:0] mem_addr,
	output logic [15:0]           mem_din,
	output logic [1:0]            mem_ds,
	output logic                  mem_we,
	output logic                  mem_oe,
	input  logic [15:0]           mem_dout
);

	localparam int ce_div_log2 = 3;	// console runs at clk_sys / 8

	logic dl_write;

	cart_info_if info_bus ();
	mbc_state_if state_bus ();

	// ------------------------------------------------------------------------
	// loader, registers, memory port
	// ------------------------------------------------------------------------
	rom_loader #(
		.ce_div_log2 (ce_div_log2)
	) loader0 (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.dl_active (dl_active),
		.dl_wr     (dl_wr),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data),
		.dl_wait   (dl_wait),
		.dl_write  (dl_write),
		.ce_cpu    (ce_cpu),
		.info      (info_bus.src)
	);

	mbc_regs regs0 (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.dl_active (dl_active),
		.ce_cpu    (ce_cpu),
		.cart_addr (cart_addr),
		.cart_wr   (cart_wr),
		.cart_di   (cart_di),
		.info      (info_bus.snk),
		.state     (state_bus.regs)
	);

	cart_mem_port #(
		.mem_addr_w (mem_addr_w)
	) port0 (
		.dl_active (dl_active),
		.dl_write  (dl_write),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data),
		.cart_addr (cart_addr),
		.cart_rd   (cart_rd),
		.cart_wr   (cart_wr),
		.cart_di   (cart_di),
		.info      (info_bus.snk),
		.state     (state_bus.map),
		.mem_addr  (mem_addr),
		.mem_din   (mem_din),
		.mem_ds    (mem_ds),
		.mem_we    (mem_we),
		.mem_oe    (mem_oe),
		.mem_dout  (mem_dout),
		.cart_do   (cart_do)
	);

endmodule

//--- bench/tb_gb_cart_tasks.svh
// ----------------------------------------------------------------------------
// rom contents and expected bytes
// ----------------------------------------------------------------------------
function automatic logic [15:0] pattern_word(input int unsigned n);
	logic [23:0] a;
	a = n[23:0];
	return {a[15:8] ^ 8'h3c, a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'h96};
endfunction

// byte the console sees at addr with a given 16k bank behind it
function automatic logic [7:0] rom_byte(input int unsigned bank, input logic [15:0] addr);
	logic [15:0] w;
	w = pattern_word((bank << 13) | addr[12:1]);
	return addr[0] ? w[15:8] : w[7:0];
endfunction

// one host word, then wait for the loader to let go
task automatic download_word(input logic [24:0] addr, input logic [15:0] data);
	int cycles;
	@(negedge clk_sys);
	dl_addr     = addr;
	dl_data     = data;
	dl_exp_addr = addr[24:1];
	dl_exp_data = data;
	dl_wr       = 1'b1;
	@(negedge clk_sys);
	dl_wr  = 1'b0;
	cycles = 0;
	while (dl_wait && cycles < 20) begin
		@(negedge clk_sys);
		cycles++;
	end
	if (dl_wait) begin
		errors++;
		$display("dl_wait still high %0d cycles after the write to %h", cycles, addr);
	end
endtask

task automatic download_header(input logic [7:0] ctype, input logic [7:0] rom_code,
	input logic [7:0] ram_code);
	dl_active = 1'b1;
	download_word(25'h146, {ctype, 8'h00});
	download_word(25'h148, {ram_code, rom_code});
endtask

// header plus the first word of every bank
task automatic download_rom(input logic [7:0] ctype, input logic [7:0] rom_code,
	input logic [7:0] ram_code, input int banks);
	download_header(ctype, rom_code, ram_code);
	for (int b = 0; b < banks; b++)
		download_word(25'(b << 14), pattern_word(b << 13));
	@(negedge clk_sys);
	dl_active = 1'b0;
endtask

// held for 8 clocks, so exactly one ce_cpu edge sees it
task automatic console_write(input logic [15:0] addr, input logic [7:0] data);
	@(negedge clk_sys);
	cart_addr = addr;
	cart_di   = data;
	cart_wr   = 1'b1;
	repeat (8) @(negedge clk_sys);
	cart_wr = 1'b0;
endtask

task automatic console_read(input logic [15:0] addr, input logic [7:0] exp);
	@(negedge clk_sys);
	cart_addr = addr;
	cart_rd   = 1'b1;
	rd_exp    = exp;
	rd_chk    = 1'b1;
	@(negedge clk_sys);
	rd_chk  = 1'b0;
	cart_rd = 1'b0;
endtask

task automatic test_done(input string name, input int err_before);
	tests_run++;
	if (errors == err_before) begin
		$display("test %s: ok", name);
	end else begin
		tests_failed++;
		$display("test %s: %0d errors", name, errors - err_before);
	end
endtask

// ----------------------------------------------------------------------------
// sequences
// ----------------------------------------------------------------------------
task automatic run_all_tests();
	int          e;
	logic [7:0]  v;
	logic [4:0]  lo5;
	logic [1:0]  r1;
	logic [7:0]  b1;
	logic [7:0]  b2;

	e = errors;
	console_read(16'h0000, 8'h00);	// nothing loaded
	download_rom(8'h01, 8'h02, 8'h03, 8);	// mbc1, 8 banks, 4 ram banks
	test_done("download", e);

	e = errors;
	console_read(16'h0000, rom_byte(0, 16'h0000));	// fixed bank 0 after load
	console_write(16'h2000, 8'h00);	// bank 0 turns into bank 1
	console_read(16'h4000, rom_byte(1, 16'h4000));
	test_done("mbc1 bank zero", e);

	e = errors;
	console_write(16'h2000, 8'h1f);
	console_read(16'h4000, rom_byte(7, 16'h4000));
	for (int i = 0; i < 4; i++) begin
		v   = 8'($urandom);
		lo5 = (v[4:0] == 5'd0) ? 5'd1 : v[4:0];
		console_write(16'h2000, v);
		console_read(16'h4000, rom_byte(lo5 & 5'h07, 16'h4000));
	end
	test_done("mbc1 bank mask", e);

	e = errors;
	console_read(16'ha000, 8'hff);	// locked
	console_write(16'h0000, 8'h0a);
	console_write(16'ha001, 8'h5a);
	console_read(16'ha001, 8'h5a);
	test_done("ram enable", e);

	e = errors;
	download_header(8'h05, 8'h02, 8'h00);
	@(negedge clk_sys);
	dl_active = 1'b0;
	console_write(16'h0000, 8'h0a);
	console_write(16'ha010, 8'h37);
	console_read(16'ha010, 8'hf7);	// top nibble reads as ones
	test_done("mbc2 ram", e);

	e = errors;
	download_header(8'h10, 8'h02, 8'h03);
	@(negedge clk_sys);
	dl_active = 1'b0;
	r1 = 2'($urandom);
	b1 = 8'($urandom);
	b2 = ~b1;
	console_write(16'h0000, 8'h0a);
	console_write(16'h4000, {6'd0, r1});
	console_write(16'ha004, b1);
	console_write(16'h4000, {6'd0, r1 ^ 2'b01});
	console_write(16'ha004, b2);
	console_read(16'ha004, b2);
	console_write(16'h4000, {6'd0, r1});
	console_read(16'ha004, b1);	// first bank kept its byte
	console_write(16'h4000, 8'h08);	// rtc select
	console_read(16'ha000, rom_byte(0, 16'h0000));
	test_done("mbc3 rtc", e);
endtask

//--- bench/tb_gb_cart.sv
`timescale 1ns/1ps

module tb_gb_cart;
	import gb_cart_pkg::*;

	localparam time period    = 100ns;
	localparam int  n_dl_word = 14;	// header and bank words over all downloads
	localparam int  n_access  = 40;	// console reads and writes, with margin

	logic                          clk_sys;
	logic                          reset;
	logic                          dl_active;
	logic                          dl_wr;
	logic [24:0]                   dl_addr;
	logic [15:0]                   dl_data;
	logic                          dl_wait;
	logic [15:0]                   cart_addr;
	logic                          cart_rd;
	logic                          cart_wr;
	logic [7:0]                    cart_di;
	logic [7:0]                    cart_do;
	logic                          ce_cpu;
	logic [mem_addr_w_default-1:0] mem_addr;
	logic [15:0]                   mem_din;
	logic [1:0]                    mem_ds;
	logic                          mem_we;
	logic                          mem_oe;
	logic [15:0]                   mem_dout;

	// ------------------------------------------------------------------------
	// expected values set by the tasks, checked by the assertions below
	// ------------------------------------------------------------------------
	logic        rd_chk;
	logic [7:0]  rd_exp;
	logic [23:0] dl_exp_addr;	// word address of the word in flight
	logic [15:0] dl_exp_data;
	int          errors;
	int          tests_run;
	int          tests_failed;
	int          ce_gap;		// clocks since the last enable or since reset
	logic        ce_seen;
	int          wait_len;		// clocks dl_wait has been high so far

	// word memory, bank 9 bits + 12 offset bits is all the map can reach
	logic [15:0] mem [0:(1<<21)-1];

	gb_cart_top #(
		.mem_addr_w (mem_addr_w_default)
	) dut0 (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.dl_active (dl_active),
		.dl_wr     (dl_wr),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data),
		.dl_wait   (dl_wait),
		.cart_addr (cart_addr),
		.cart_rd   (cart_rd),
		.cart_wr   (cart_wr),
		.cart_di   (cart_di),
		.cart_do   (cart_do),
		.ce_cpu    (ce_cpu),
		.mem_addr  (mem_addr),
		.mem_din   (mem_din),
		.mem_ds    (mem_ds),
		.mem_we    (mem_we),
		.mem_oe    (mem_oe),
		.mem_dout  (mem_dout)
	);

	assign mem_dout = mem[mem_addr[20:0]];	// async read

	always @(posedge clk_sys) begin
		if (ce_cpu && mem_we) begin
			if (mem_ds[0])
				mem[mem_addr[20:0]][7:0] <= mem_din[7:0];	// low lane
			if (mem_ds[1])
				mem[mem_addr[20:0]][15:8] <= mem_din[15:8];
		end
	end

	// enable spacing and wait length, counted from the sampled values
	always @(posedge clk_sys) begin
		if (reset) begin
			ce_gap  <= 0;
			ce_seen <= 1'b0;
		end else if (ce_cpu) begin
			ce_gap  <= 0;
			ce_seen <= 1'b1;
		end else begin
			ce_gap <= ce_gap + 1;
		end
	end

	always @(posedge clk_sys) begin
		if (reset || !dl_wait)
			wait_len <= 0;
		else
			wait_len <= wait_len + 1;
	end

	// ------------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------------
	a_read_data: assert property (@(posedge clk_sys) disable iff (reset)
		rd_chk |-> (cart_do == rd_exp)) else begin
		errors++;
		$display("** Error cart_do: got %h, expected %h at cart_addr %h",
			$sampled(cart_do), $sampled(rd_exp), $sampled(cart_addr));
	end

	a_dl_addr: assert property (@(posedge clk_sys) disable iff (reset)
		(dl_active && ce_cpu && mem_we) |-> (mem_addr == dl_exp_addr)) else begin
		errors++;
		$display("** Error mem_addr: got %h, expected %h",
			$sampled(mem_addr), $sampled(dl_exp_addr));
	end

	a_dl_data: assert property (@(posedge clk_sys) disable iff (reset)
		(dl_active && ce_cpu && mem_we) |-> (mem_din == dl_exp_data)) else begin
		errors++;
		$display("** Error mem_din: got %h, expected %h",
			$sampled(mem_din), $sampled(dl_exp_data));
	end

	// download words are whole words, both lanes
	a_dl_ds: assert property (@(posedge clk_sys) disable iff (reset)
		(dl_active && ce_cpu && mem_we) |-> (mem_ds == 2'b11)) else begin
		errors++;
		$display("** Error mem_ds: got %h, expected %h", $sampled(mem_ds), 2'b11);
	end

	a_dl_wait_rise: assert property (@(posedge clk_sys) disable iff (reset)
		dl_wr |=> dl_wait) else begin
		errors++;
		$display("dl_wait did not rise the cycle after dl_wr");
	end

	a_dl_wait_len: assert property (@(posedge clk_sys) disable iff (reset)
		dl_wait |-> (wait_len < 16)) else begin
		errors++;
		$display("dl_wait stayed high for more than 16 cycles");
	end

	a_ce_period: assert property (@(posedge clk_sys) disable iff (reset)
		(ce_cpu && ce_seen) |-> (ce_gap == 7)) else begin
		errors++;
		$display("ce_cpu came %0d clocks after the previous pulse, not 8",
			$sampled(ce_gap) + 1);
	end

	a_ce_late: assert property (@(posedge clk_sys) disable iff (reset)
		!ce_cpu |-> (ce_gap < 7)) else begin
		errors++;
		$display("ce_cpu missing for more than 8 clocks");
	end

	a_mem_oe: assert property (@(posedge clk_sys) disable iff (reset)
		!dl_active |-> (mem_oe == cart_rd)) else begin
		errors++;
		$display("** Error mem_oe: got %h, expected %h", $sampled(mem_oe), $sampled(cart_rd));
	end

	`include "tb_gb_cart_tasks.svh"

	initial begin
		clk_sys = 1'b0;
		forever #(period / 2) clk_sys = ~clk_sys;
	end

	// watchdog, sized from the number of downloads and accesses
	initial begin
		#((n_dl_word * 50 + n_access * 20 + 20) * period);
		$display("timeout: the run did not finish in the expected number of cycles");
		$display("TB FAILED");
		$finish;
	end

	initial begin
		void'($urandom(32'hdfd4));
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		reset        = 1'b1;
		dl_active    = 1'b0;
		dl_wr        = 1'b0;
		dl_addr      = '0;
		dl_data      = '0;
		cart_addr    = '0;
		cart_rd      = 1'b0;
		cart_wr      = 1'b0;
		cart_di      = '0;
		rd_chk       = 1'b0;
		rd_exp       = '0;
		dl_exp_addr  = '0;
		dl_exp_data  = '0;
		repeat (3) @(negedge clk_sys);
		reset = 1'b0;

		run_all_tests();

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

//--- gb_cart_top.f
+incdir+bench
common/gb_cart_pkg.sv
common/cart_info_if.sv
common/mbc_state_if.sv
loader/rom_loader.sv
mbc/mbc_regs.sv
mbc/cart_mem_port.sv
logic/gb_cart_top.sv
bench/tb_gb_cart.sv

//--- Makefile
# Verilator build for the cartridge MBC block and its testbench

OBJ_DIR := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f gb_cart_top.f --top-module gb_cart_top

sim:
	verilator --binary --timing --assert -f gb_cart_top.f --top-module tb_gb_cart \
		--Mdir $(OBJ_DIR) -o tb_gb_cart
	./$(OBJ_DIR)/tb_gb_cart | tee sim.log
	grep -q "^TB PASSED$$" sim.log

clean:
	rm -rf $(OBJ_DIR) sim.log
